// ==== cia_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cia_checker import cia_pkg::*; (
  input  wire            clk,
  input  wire            int_reset,
  input  wire            phi2,
  input  wire            cs_n,
  input  wire            rw,
  input  wire reg_addr_t rs,
  input  wire byte_t     db_in,
  input  wire byte_t     pa_in,
  input  wire byte_t     pb_in,
  input  wire byte_t     db_out,
  input  wire byte_t     pa_out,
  input  wire byte_t     pb_out,
  output int             errors
);

  byte_t     sh_pra;
  byte_t     sh_prb;
  byte_t     sh_ddra;
  byte_t     sh_ddrb;
  byte_t     sh_cra;
  byte_t     sh_crb;
  byte_t     exp_pa;
  byte_t     exp_pb;
  byte_t     pb_care;
  logic      rd_pending;
  logic      rd_check;
  reg_addr_t rd_addr;
  byte_t     rd_exp;
  byte_t     rd_care;

  // Expected read byte from the shadow registers and the pins
  function automatic byte_t exp_read(input reg_addr_t addr);
    byte_t load_bit;
    load_bit = byte_t'(1) << CR_LOAD;
    case (addr)
      ADDR_PRA:  return pa_in;
      ADDR_PRB:  return pb_in;
      ADDR_DDRA: return sh_ddra;
      ADDR_DDRB: return sh_ddrb;
      ADDR_CRA:  return sh_cra & ~load_bit;
      ADDR_CRB:  return sh_crb & ~load_bit;
      default:   return 8'h00;
    endcase
  endfunction

  // Counts and ICR depend on timer state
  function automatic byte_t read_care(input reg_addr_t addr);
    byte_t no_start;
    no_start = ~(byte_t'(1) << CR_START);
    case (addr)
      ADDR_TA_LO, ADDR_TA_HI, ADDR_TB_LO, ADDR_TB_HI, ADDR_ICR: return 8'h00;
      // One-shot timers stop on their own
      ADDR_CRA: return sh_cra[CR_RUNMODE] ? no_start : 8'hff;
      ADDR_CRB: return sh_crb[CR_RUNMODE] ? no_start : 8'hff;
      default:  return 8'hff;
    endcase
  endfunction

  always @(posedge clk) begin
    if (int_reset) begin
      sh_pra     <= 8'h00;
      sh_prb     <= 8'h00;
      sh_ddra    <= 8'h00;
      sh_ddrb    <= 8'h00;
      sh_cra     <= 8'h00;
      sh_crb     <= 8'h00;
      exp_pa     <= 8'hff;
      exp_pb     <= 8'hff;
      pb_care    <= 8'hff;
      rd_pending <= 1'b0;
      rd_check   <= 1'b0;
    end else begin
      rd_check <= rd_pending;
      if (rd_pending) begin
        rd_exp  <= exp_read(rd_addr);
        rd_care <= read_care(rd_addr);
      end
      rd_pending <= !cs_n && rw;
      rd_addr    <= rs;
      // Pins follow the registers on phi2, PB6/PB7 belong to the timers with PBON
      if (phi2) begin
        exp_pa  <= sh_pra | ~sh_ddra;
        exp_pb  <= sh_prb | ~sh_ddrb;
        pb_care <= {~sh_crb[CR_PBON], ~sh_cra[CR_PBON], 6'h3f};
      end
      if (!cs_n && !rw) begin
        case (rs)
          ADDR_PRA:  sh_pra  <= db_in;
          ADDR_PRB:  sh_prb  <= db_in;
          ADDR_DDRA: sh_ddra <= db_in;
          ADDR_DDRB: sh_ddrb <= db_in;
          ADDR_CRA:  sh_cra  <= db_in;
          ADDR_CRB:  sh_crb  <= db_in;
          default: ;
        endcase
      end
    end
  end

  initial errors = 0;

  always @(negedge clk) begin
    if (!int_reset) begin
      if (pa_out !== exp_pa) begin
        $display("** Error @%0t: pa_out %h, expected %h", $time, pa_out, exp_pa);
        errors++;
      end
      if ((pb_out & pb_care) !== (exp_pb & pb_care)) begin
        $display("** Error @%0t: pb_out %h, expected %h under mask %h",
                 $time, pb_out, exp_pb, pb_care);
        errors++;
      end
      if (rd_check && ((db_out & rd_care) !== (rd_exp & rd_care))) begin
        $display("** Error @%0t: read of register %0d gave %h, expected %h",
                 $time, rd_addr, db_out, rd_exp);
        errors++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cia_interrupt.sv ====
`timescale 1ns/1ps
`default_nettype none

module cia_interrupt import cia_pkg::*; (
  input  wire        clk,
  input  wire        int_reset,
  input  wire byte_t db_in,
  input  wire        wr_icr,
  input  wire        icr_read,
  input  wire        ta_underflow,
  input  wire        tb_underflow,
  input  wire        flag_event,
  output irq_src_t   flags,
  output logic       irq_n
);

  irq_src_t mask;
  irq_src_t sources;

  always_comb begin
    sources           = '0;
    sources[IRQ_TA]   = ta_underflow;
    sources[IRQ_TB]   = tb_underflow;
    sources[IRQ_FLAG] = flag_event;
  end

  // Bit 7 picks set or clear
  always_ff @(posedge clk) begin
    if (int_reset) begin
      mask <= '0;
    end else if (wr_icr) begin
      if (db_in[ICR_IRQ_BIT]) begin
        mask <= mask | (db_in[4:0] & IRQ_USED);
      end else begin
        mask <= mask & ~db_in[4:0];
      end
    end
  end

  // A source pulse in the clearing cycle survives
  always_ff @(posedge clk) begin
    if (int_reset) begin
      flags <= '0;
    end else if (icr_read) begin
      flags <= sources;
    end else begin
      flags <= flags | sources;
    end
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      irq_n <= 1'b1;
    end else if (icr_read) begin
      irq_n <= 1'b1;
    end else begin
      irq_n <= ~|(flags & mask);
    end
  end

endmodule

`default_nettype wire

// ==== cia_io_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module cia_io_ports import cia_pkg::*; (
  input  wire        clk,
  input  wire        int_reset,
  input  wire        phi2,
  input  wire byte_t db_in,
  input  wire        wr_pra,
  input  wire        wr_prb,
  input  wire        wr_ddra,
  input  wire        wr_ddrb,
  input  wire        prb_access,
  input  wire byte_t cra,
  input  wire byte_t crb,
  input  wire        ta_pb_level,
  input  wire        tb_pb_level,
  input  wire        flag_n,
  output byte_t      pa_out,
  output byte_t      pb_out,
  output byte_t      pra,
  output byte_t      prb,
  output byte_t      ddra,
  output byte_t      ddrb,
  output logic       pc_n,
  output logic       flag_event
);

  byte_t pb_src;
  logic  flag_n_q;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pra  <= PORT_RESET;
      prb  <= PORT_RESET;
      ddra <= PORT_RESET;
      ddrb <= PORT_RESET;
    end else begin
      if (wr_pra) begin
        pra <= db_in;
      end
      if (wr_prb) begin
        prb <= db_in;
      end
      if (wr_ddra) begin
        ddra <= db_in;
      end
      if (wr_ddrb) begin
        ddrb <= db_in;
      end
    end
  end

  // Timers take over PB6 and PB7
  always_comb begin
    pb_src = prb;
    if (cra[CR_PBON]) begin
      pb_src[6] = ta_pb_level;
    end
    if (crb[CR_PBON]) begin
      pb_src[7] = tb_pb_level;
    end
  end

  // Input bits float high
  always_ff @(posedge clk) begin
    if (int_reset) begin
      pa_out <= PIN_RESET;
      pb_out <= PIN_RESET;
    end else if (phi2) begin
      pa_out <= pra | ~ddra;
      pb_out <= pb_src | ~ddrb;
    end
  end

  // Handshake strobe
  always_ff @(posedge clk) begin
    if (int_reset) begin
      pc_n <= 1'b1;
    end else if (prb_access) begin
      pc_n <= 1'b0;
    end else if (phi2) begin
      pc_n <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      flag_n_q <= 1'b1;
    end else if (phi2) begin
      flag_n_q <= flag_n;
    end
  end

  // Falling edge only
  assign flag_event = phi2 && flag_n_q && !flag_n;

endmodule

`default_nettype wire

// ==== cia_pkg.sv ====
`default_nettype none

package cia_pkg;

  typedef logic [3:0]  reg_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] count_t;
  typedef logic [4:0]  irq_src_t;

  // Register map
  localparam reg_addr_t ADDR_PRA   = 4'd0;
  localparam reg_addr_t ADDR_PRB   = 4'd1;
  localparam reg_addr_t ADDR_DDRA  = 4'd2;
  localparam reg_addr_t ADDR_DDRB  = 4'd3;
  localparam reg_addr_t ADDR_TA_LO = 4'd4;
  localparam reg_addr_t ADDR_TA_HI = 4'd5;
  localparam reg_addr_t ADDR_TB_LO = 4'd6;
  localparam reg_addr_t ADDR_TB_HI = 4'd7;
  localparam reg_addr_t ADDR_NONE  = 4'd8;
  localparam reg_addr_t ADDR_ICR   = 4'd13;
  localparam reg_addr_t ADDR_CRA   = 4'd14;
  localparam reg_addr_t ADDR_CRB   = 4'd15;

  // Timer control register bits
  localparam int CR_START   = 0;
  localparam int CR_PBON    = 1;
  localparam int CR_OUTMODE = 2;
  localparam int CR_RUNMODE = 3;
  localparam int CR_LOAD    = 4;
  localparam int CR_INMODE  = 5;

  // Interrupt sources
  localparam int       IRQ_TA      = 0;
  localparam int       IRQ_TB      = 1;
  localparam int       IRQ_FLAG    = 4;
  localparam irq_src_t IRQ_USED    = 5'b10011;
  localparam int       ICR_IRQ_BIT = 7;

  // Reset values
  localparam byte_t  PORT_RESET        = 8'h00;
  localparam byte_t  PIN_RESET         = 8'hff;
  localparam byte_t  CR_RESET          = 8'h00;
  localparam count_t TIMER_RESET_LATCH = 16'hffff;
  localparam count_t COUNT_RESET       = 16'h0000;

endpackage

`default_nettype wire

// ==== cia_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module cia_read_mux import cia_pkg::*; (
  input  wire            clk,
  input  wire            int_reset,
  input  wire reg_addr_t rd_sel,
  input  wire byte_t     pa_in,
  input  wire byte_t     pb_in,
  input  wire byte_t     ddra,
  input  wire byte_t     ddrb,
  input  wire count_t    ta_count,
  input  wire count_t    tb_count,
  input  wire irq_src_t  flags,
  input  wire            irq_n,
  input  wire byte_t     cra,
  input  wire byte_t     crb,
  output byte_t          db_out
);

  byte_t icr_value;
  byte_t cra_value;
  byte_t crb_value;

  // Force load never reads back
  always_comb begin
    icr_value              = byte_t'(flags);
    icr_value[ICR_IRQ_BIT] = ~irq_n;
    cra_value              = cra;
    cra_value[CR_LOAD]     = 1'b0;
    crb_value              = crb;
    crb_value[CR_LOAD]     = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      db_out <= '0;
    end else begin
      case (rd_sel)
        ADDR_PRA:   db_out <= pa_in;
        ADDR_PRB:   db_out <= pb_in;
        ADDR_DDRA:  db_out <= ddra;
        ADDR_DDRB:  db_out <= ddrb;
        ADDR_TA_LO: db_out <= ta_count[7:0];
        ADDR_TA_HI: db_out <= ta_count[15:8];
        ADDR_TB_LO: db_out <= tb_count[7:0];
        ADDR_TB_HI: db_out <= tb_count[15:8];
        ADDR_ICR:   db_out <= icr_value;
        ADDR_CRA:   db_out <= cra_value;
        ADDR_CRB:   db_out <= crb_value;
        default:    db_out <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== cia_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cia_reg_decode import cia_pkg::*; (
  input  wire            clk,
  input  wire            int_reset,
  input  wire            cs_n,
  input  wire            rw,
  input  wire reg_addr_t rs,
  output logic           wr_pra,
  output logic           wr_prb,
  output logic           wr_ddra,
  output logic           wr_ddrb,
  output logic           wr_ta_lo,
  output logic           wr_ta_hi,
  output logic           wr_tb_lo,
  output logic           wr_tb_hi,
  output logic           wr_icr,
  output logic           wr_cra,
  output logic           wr_crb,
  output reg_addr_t      rd_sel,
  output logic           icr_read,
  output logic           prb_access
);

  logic wr_cycle;
  logic rd_cycle;

  assign wr_cycle = !cs_n && !rw;
  assign rd_cycle = !cs_n && rw;

  // Write strobes, addresses 8 to 12 have none
  assign wr_pra   = wr_cycle && (rs == ADDR_PRA);
  assign wr_prb   = wr_cycle && (rs == ADDR_PRB);
  assign wr_ddra  = wr_cycle && (rs == ADDR_DDRA);
  assign wr_ddrb  = wr_cycle && (rs == ADDR_DDRB);
  assign wr_ta_lo = wr_cycle && (rs == ADDR_TA_LO);
  assign wr_ta_hi = wr_cycle && (rs == ADDR_TA_HI);
  assign wr_tb_lo = wr_cycle && (rs == ADDR_TB_LO);
  assign wr_tb_hi = wr_cycle && (rs == ADDR_TB_HI);
  assign wr_icr   = wr_cycle && (rs == ADDR_ICR);
  assign wr_cra   = wr_cycle && (rs == ADDR_CRA);
  assign wr_crb   = wr_cycle && (rs == ADDR_CRB);

  // Reads and writes of PRB both strobe pc_n
  assign prb_access = !cs_n && (rs == ADDR_PRB);

  // Read select holds the last address read
  always_ff @(posedge clk) begin
    if (int_reset) begin
      rd_sel   <= ADDR_NONE;
      icr_read <= 1'b0;
    end else begin
      icr_read <= rd_cycle && (rs == ADDR_ICR);
      if (rd_cycle) begin
        rd_sel <= rs;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cia_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cia_timer import cia_pkg::*; (
  input  wire        clk,
  input  wire        int_reset,
  input  wire        phi2,
  input  wire byte_t db_in,
  input  wire        wr_lo,
  input  wire        wr_hi,
  input  wire        wr_cr,
  input  wire        ext_tick,
  output count_t     count,
  output byte_t      cr,
  output logic       underflow,
  output logic       pb_level
);

  byte_t latch_lo;
  byte_t latch_hi;
  logic  tick;
  logic  force_load;
  logic  pulse_q;
  logic  toggle_q;

  // Either every phi2 or cascaded underflows
  assign tick       = phi2 && (!cr[CR_INMODE] || ext_tick);
  assign force_load = phi2 && cr[CR_LOAD];
  assign underflow  = tick && cr[CR_START] && !cr[CR_LOAD] && (count == '0);

  always_ff @(posedge clk) begin
    if (int_reset) begin
      {latch_hi, latch_lo} <= TIMER_RESET_LATCH;
    end else begin
      if (wr_lo) begin
        latch_lo <= db_in;
      end
      if (wr_hi) begin
        latch_hi <= db_in;
      end
    end
  end

  // High byte write loads a stopped timer
  always_ff @(posedge clk) begin
    if (int_reset) begin
      count <= COUNT_RESET;
    end else if (wr_hi && !cr[CR_START]) begin
      count <= {db_in, latch_lo};
    end else if (force_load || underflow) begin
      count <= {latch_hi, latch_lo};
    end else if (tick && cr[CR_START]) begin
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      cr <= CR_RESET;
    end else if (wr_cr) begin
      cr <= db_in;
    end else begin
      if (force_load) begin
        cr[CR_LOAD] <= 1'b0;
      end
      // One-shot stops itself
      if (underflow && cr[CR_RUNMODE]) begin
        cr[CR_START] <= 1'b0;
      end
    end
  end

  // PB output state, pulse lasts until the next phi2 edge
  always_ff @(posedge clk) begin
    if (int_reset) begin
      pulse_q  <= 1'b0;
      toggle_q <= 1'b0;
    end else begin
      if (underflow) begin
        pulse_q <= 1'b1;
      end else if (phi2) begin
        pulse_q <= 1'b0;
      end
      if (wr_cr && db_in[CR_START]) begin
        toggle_q <= 1'b1;
      end else if (underflow) begin
        toggle_q <= !toggle_q;
      end
    end
  end

  assign pb_level = cr[CR_OUTMODE] ? toggle_q : pulse_q;

endmodule

`default_nettype wire

// ==== cia_top.f ====
cia_pkg.sv
cia_reg_decode.sv
cia_io_ports.sv
cia_timer.sv
cia_interrupt.sv
cia_read_mux.sv
cia_top.sv
cia_checker.sv
tb_cia_top.sv

// ==== cia_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cia_top import cia_pkg::*; (
  input  wire            clk,
  input  wire            int_reset,
  input  wire            phi2,
  input  wire            cs_n,
  input  wire            rw,
  input  wire reg_addr_t rs,
  input  wire byte_t     db_in,
  input  wire byte_t     pa_in,
  input  wire byte_t     pb_in,
  input  wire            flag_n,
  output byte_t          db_out,
  output byte_t          pa_out,
  output byte_t          pb_out,
  output logic           pc_n,
  output logic           irq_n
);

  logic      wr_pra;
  logic      wr_prb;
  logic      wr_ddra;
  logic      wr_ddrb;
  logic      wr_ta_lo;
  logic      wr_ta_hi;
  logic      wr_tb_lo;
  logic      wr_tb_hi;
  logic      wr_icr;
  logic      wr_cra;
  logic      wr_crb;
  reg_addr_t rd_sel;
  logic      icr_read;
  logic      prb_access;
  byte_t     ddra;
  byte_t     ddrb;
  byte_t     cra;
  byte_t     crb;
  count_t    ta_count;
  count_t    tb_count;
  logic      ta_underflow;
  logic      tb_underflow;
  logic      ta_pb_level;
  logic      tb_pb_level;
  logic      flag_event;
  irq_src_t  flags;

  cia_reg_decode reg_decode_i (
    .clk        (clk),
    .int_reset  (int_reset),
    .cs_n       (cs_n),
    .rw         (rw),
    .rs         (rs),
    .wr_pra     (wr_pra),
    .wr_prb     (wr_prb),
    .wr_ddra    (wr_ddra),
    .wr_ddrb    (wr_ddrb),
    .wr_ta_lo   (wr_ta_lo),
    .wr_ta_hi   (wr_ta_hi),
    .wr_tb_lo   (wr_tb_lo),
    .wr_tb_hi   (wr_tb_hi),
    .wr_icr     (wr_icr),
    .wr_cra     (wr_cra),
    .wr_crb     (wr_crb),
    .rd_sel     (rd_sel),
    .icr_read   (icr_read),
    .prb_access (prb_access)
  );

  // Port registers are only visible on the pins
  cia_io_ports io_ports_i (
    .clk         (clk),
    .int_reset   (int_reset),
    .phi2        (phi2),
    .db_in       (db_in),
    .wr_pra      (wr_pra),
    .wr_prb      (wr_prb),
    .wr_ddra     (wr_ddra),
    .wr_ddrb     (wr_ddrb),
    .prb_access  (prb_access),
    .cra         (cra),
    .crb         (crb),
    .ta_pb_level (ta_pb_level),
    .tb_pb_level (tb_pb_level),
    .flag_n      (flag_n),
    .pa_out      (pa_out),
    .pb_out      (pb_out),
    .pra         (),
    .prb         (),
    .ddra        (ddra),
    .ddrb        (ddrb),
    .pc_n        (pc_n),
    .flag_event  (flag_event)
  );

  cia_timer timer_a (
    .clk       (clk),
    .int_reset (int_reset),
    .phi2      (phi2),
    .db_in     (db_in),
    .wr_lo     (wr_ta_lo),
    .wr_hi     (wr_ta_hi),
    .wr_cr     (wr_cra),
    .ext_tick  (1'b0),
    .count     (ta_count),
    .cr        (cra),
    .underflow (ta_underflow),
    .pb_level  (ta_pb_level)
  );

  // Cascades on timer A underflows
  cia_timer timer_b (
    .clk       (clk),
    .int_reset (int_reset),
    .phi2      (phi2),
    .db_in     (db_in),
    .wr_lo     (wr_tb_lo),
    .wr_hi     (wr_tb_hi),
    .wr_cr     (wr_crb),
    .ext_tick  (ta_underflow),
    .count     (tb_count),
    .cr        (crb),
    .underflow (tb_underflow),
    .pb_level  (tb_pb_level)
  );

  cia_interrupt interrupt_i (
    .clk          (clk),
    .int_reset    (int_reset),
    .db_in        (db_in),
    .wr_icr       (wr_icr),
    .icr_read     (icr_read),
    .ta_underflow (ta_underflow),
    .tb_underflow (tb_underflow),
    .flag_event   (flag_event),
    .flags        (flags),
    .irq_n        (irq_n)
  );

  cia_read_mux read_mux_i (
    .clk       (clk),
    .int_reset (int_reset),
    .rd_sel    (rd_sel),
    .pa_in     (pa_in),
    .pb_in     (pb_in),
    .ddra      (ddra),
    .ddrb      (ddrb),
    .ta_count  (ta_count),
    .tb_count  (tb_count),
    .flags     (flags),
    .irq_n     (irq_n),
    .cra       (cra),
    .crb       (crb),
    .db_out    (db_out)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CIA testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f cia_top.f --top-module tb_cia_top -o sim_cia
./obj_dir/sim_cia | tee sim.log
if grep -q "=== PASS ===" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb_cia_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cia_top import cia_pkg::*; ();

  logic      clk;
  logic      int_reset;
  logic      phi2;
  logic      cs_n;
  logic      rw;
  reg_addr_t rs;
  byte_t     db_in;
  byte_t     pa_in;
  byte_t     pb_in;
  logic      flag_n;
  byte_t     db_out;
  byte_t     pa_out;
  byte_t     pb_out;
  logic      pc_n;
  logic      irq_n;
  int        chk_errors;
  int        seq_errors;
  int        cycles;
  int        n_val;
  int        m_val;
  byte_t     rdata;
  irq_src_t  exp_mask;

  cia_top cia_top_i (
    .clk(clk), .int_reset(int_reset), .phi2(phi2), .cs_n(cs_n), .rw(rw), .rs(rs),
    .db_in(db_in), .pa_in(pa_in), .pb_in(pb_in), .flag_n(flag_n), .db_out(db_out),
    .pa_out(pa_out), .pb_out(pb_out), .pc_n(pc_n), .irq_n(irq_n)
  );

  cia_checker checker_i (
    .clk(clk), .int_reset(int_reset), .phi2(phi2), .cs_n(cs_n), .rw(rw), .rs(rs),
    .db_in(db_in), .pa_in(pa_in), .pb_in(pb_in), .db_out(db_out), .pa_out(pa_out),
    .pb_out(pb_out), .errors(chk_errors)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Reload takes the tick after zero and B counts whole A periods
  function automatic int underflow_ticks(input int n, input int m, input bit cascade);
    if (cascade) begin
      return (m + 1) * (n + 1);
    end
    return n + 1;
  endfunction

  function automatic byte_t exp_icr(input irq_src_t flags, input irq_src_t mask);
    return {|(flags & mask), 2'b00, flags};
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input byte_t data);
    cs_n  = 1'b0;
    rw    = 1'b0;
    rs    = addr;
    db_in = data;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    rw   = 1'b1;
  endtask

  task automatic read_reg(input reg_addr_t addr, output byte_t data);
    cs_n = 1'b0;
    rw   = 1'b1;
    rs   = addr;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    @(posedge clk);
    #1;
    data = db_out;
  endtask

  task automatic compare_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("** Error @%0t: %s is %h, expected %h", $time, what, got, exp);
      seq_errors++;
    end
  endtask

  // Bits 2 and 3 of the mask do not exist
  task automatic set_icr(input byte_t data);
    write_reg(ADDR_ICR, data);
    if (data[7]) begin
      exp_mask = exp_mask | (data[4:0] & 5'b10011);
    end else begin
      exp_mask = exp_mask & ~data[4:0];
    end
  endtask

  task automatic poll_irq(input int limit, output int n);
    n = 0;
    while (irq_n === 1'b1 && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (irq_n === 1'b1) begin
      $display("Timed out after %0d cycles waiting for irq_n to fall", limit);
      seq_errors++;
    end
  endtask

  task automatic time_pb6_change(input int limit, output int n);
    logic start_level;
    start_level = pb_out[6];
    n = 0;
    while (pb_out[6] === start_level && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (pb_out[6] === start_level) begin
      $display("Timed out after %0d cycles waiting for PB6 to change", limit);
      seq_errors++;
    end
  endtask

  task automatic expect_irq_high(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      if (irq_n !== 1'b1) begin
        $display("** Error @%0t: irq_n low for a source that is masked off", $time);
        seq_errors++;
      end
    end
  endtask

  task automatic pc_strobe_test;
    cs_n = 1'b0;
    rw   = 1'b1;
    rs   = ADDR_PRB;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    if (pc_n !== 1'b0) begin
      $display("** Error @%0t: pc_n stayed high after a PRB access", $time);
      seq_errors++;
    end
    @(posedge clk);
    #1;
    if (pc_n !== 1'b1) begin
      $display("** Error @%0t: pc_n did not return high on phi2", $time);
      seq_errors++;
    end
  endtask

  task automatic check_underflow(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("** Error @%0t: %s underflowed after %0d ticks, expected %0d",
               $time, what, got, exp);
      seq_errors++;
    end
  endtask

  initial begin
    int_reset  = 1'b1;
    phi2       = 1'b1;
    cs_n       = 1'b1;
    rw         = 1'b1;
    rs         = ADDR_PRA;
    db_in      = 8'h00;
    pa_in      = 8'h00;
    pb_in      = 8'h00;
    flag_n     = 1'b1;
    seq_errors = 0;
    exp_mask   = '0;
    void'($urandom(29));
    repeat (2) @(posedge clk);
    #1;
    int_reset = 1'b0;

    // Reset state before any access
    if (irq_n !== 1'b1 || pc_n !== 1'b1) begin
      $display("** Error @%0t: irq_n %b pc_n %b after reset", $time, irq_n, pc_n);
      seq_errors++;
    end
    compare_byte("pa_out", pa_out, 8'hff);
    compare_byte("pb_out", pb_out, 8'hff);
    compare_byte("db_out", db_out, 8'h00);

    // Ports and DDRs with some phi2-low cycles in between
    repeat (16) begin
      pa_in = byte_t'($urandom);
      pb_in = byte_t'($urandom);
      write_reg(ADDR_PRA, byte_t'($urandom));
      write_reg(ADDR_PRB, byte_t'($urandom));
      write_reg(ADDR_DDRA, byte_t'($urandom));
      phi2 = 1'b0;
      write_reg(ADDR_DDRB, byte_t'($urandom));
      phi2 = 1'b1;
      idle_cycles(1);
      read_reg(ADDR_PRA, rdata);
      read_reg(ADDR_PRB, rdata);
      read_reg(ADDR_DDRA, rdata);
      read_reg(ADDR_DDRB, rdata);
    end
    read_reg(ADDR_CRA, rdata);
    read_reg(4'd10, rdata);
    pc_strobe_test();

    // Timer A one-shot
    n_val = $urandom % 36 + 5;
    set_icr(8'h81);
    write_reg(ADDR_TA_LO, n_val[7:0]);
    write_reg(ADDR_TA_HI, n_val[15:8]);
    write_reg(ADDR_CRA, 8'h09);
    poll_irq(100, cycles);
    check_underflow("timer A", cycles - 1, underflow_ticks(n_val, 0, 1'b0));
    read_reg(ADDR_ICR, rdata);
    compare_byte("ICR", rdata, exp_icr(5'b00001, exp_mask));
    read_reg(ADDR_CRA, rdata);
    compare_byte("CRA", rdata, 8'h08);
    idle_cycles(underflow_ticks(n_val, 0, 1'b0) + 4);
    read_reg(ADDR_TA_LO, rdata);
    compare_byte("TA low", rdata, n_val[7:0]);
    read_reg(ADDR_TA_HI, rdata);
    compare_byte("TA high", rdata, n_val[15:8]);
    read_reg(ADDR_ICR, rdata);
    compare_byte("ICR", rdata, 8'h00);

    // Continuous toggle on PB6
    set_icr(8'h01);
    write_reg(ADDR_PRB, 8'h00);
    write_reg(ADDR_DDRB, 8'hc0);
    n_val = $urandom % 10 + 3;
    write_reg(ADDR_TA_LO, n_val[7:0]);
    write_reg(ADDR_TA_HI, n_val[15:8]);
    write_reg(ADDR_CRA, 8'h07);
    time_pb6_change(10, cycles);
    repeat (2) begin
      time_pb6_change(100, cycles);
      check_underflow("PB6 toggle", cycles, underflow_ticks(n_val, 0, 1'b0));
    end

    // Timer B counting timer A underflows
    write_reg(ADDR_CRA, 8'h00);
    n_val = $urandom % 6 + 3;
    m_val = $urandom % 4 + 2;
    write_reg(ADDR_TA_LO, n_val[7:0]);
    write_reg(ADDR_TA_HI, n_val[15:8]);
    write_reg(ADDR_TB_LO, m_val[7:0]);
    write_reg(ADDR_TB_HI, m_val[15:8]);
    write_reg(ADDR_CRB, 8'h29);
    read_reg(ADDR_ICR, rdata);
    set_icr(8'h82);
    write_reg(ADDR_CRA, 8'h01);
    poll_irq(200, cycles);
    check_underflow("timer B", cycles - 1, underflow_ticks(n_val, m_val, 1'b1));
    read_reg(ADDR_ICR, rdata);
    compare_byte("ICR", rdata, exp_icr(5'b00011, exp_mask));
    write_reg(ADDR_CRA, 8'h00);
    read_reg(ADDR_CRB, rdata);
    compare_byte("CRB", rdata, 8'h28);
    read_reg(ADDR_ICR, rdata);

    // Mask set then clear leaves only FLAG
    set_icr(8'h93);
    set_icr(8'h03);
    n_val = $urandom % 8 + 3;
    write_reg(ADDR_TA_LO, n_val[7:0]);
    write_reg(ADDR_TA_HI, n_val[15:8]);
    write_reg(ADDR_CRA, 8'h09);
    expect_irq_high(underflow_ticks(n_val, 0, 1'b0) + 3);
    read_reg(ADDR_ICR, rdata);
    compare_byte("ICR", rdata, exp_icr(5'b00001, exp_mask));
    flag_n = 1'b0;
    poll_irq(20, cycles);
    read_reg(ADDR_ICR, rdata);
    compare_byte("ICR", rdata, exp_icr(5'b10000, exp_mask));
    read_reg(ADDR_ICR, rdata);
    compare_byte("ICR", rdata, 8'h00);
    flag_n = 1'b1;
    expect_irq_high(3);
    read_reg(ADDR_ICR, rdata);
    compare_byte("ICR", rdata, 8'h00);
    pc_strobe_test();

    idle_cycles(2);
    $display("Errors: checker %0d, sequence %0d", chk_errors, seq_errors);
    if (chk_errors + seq_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #200000;
    $display("Simulation stopped by the watchdog before the sequences finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
